//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_alu_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- alu_arith_unit.sv
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_arith_unit (
    input  alu_data_pkg::alu_req_t req,
    output alu_data_pkg::alu_out_t out
);
    import alu_cmd_pkg::*;

    arith_cmd_e                   cmd;
    logic [`ALU_RES_BITS-1:0]     a_ext;
    logic [`ALU_RES_BITS-1:0]     b_ext;
    logic [`ALU_RES_BITS-1:0]     a_sext;
    logic [`ALU_RES_BITS-1:0]     b_sext;
    logic [`ALU_RES_BITS-1:0]     cin_ext;
    logic signed [`ALU_WIDTH-1:0] a_s;
    logic signed [`ALU_WIDTH-1:0] b_s;
    logic                         msb_a;
    logic                         msb_b;

    assign cmd     = arith_cmd_e'(req.cmd);
    assign a_ext   = {1'b0, req.opa};
    assign b_ext   = {1'b0, req.opb};
    assign cin_ext = {{`ALU_WIDTH{1'b0}}, req.cin};

    // signed forms carry the sign into bit 8.
    assign msb_a  = req.opa[`ALU_WIDTH-1];
    assign msb_b  = req.opb[`ALU_WIDTH-1];
    assign a_sext = {msb_a, req.opa};
    assign b_sext = {msb_b, req.opb};
    assign a_s    = req.opa;
    assign b_s    = req.opb;

    always_comb begin
        out = '0;
        case (cmd)
            CMD_ADD:     out.res = a_ext + b_ext;
            CMD_SUB:     out.res = a_ext - b_ext;
            CMD_ADD_CIN: out.res = a_ext + b_ext + cin_ext;
            CMD_SUB_CIN: out.res = a_ext - b_ext - cin_ext;
            CMD_INC_A:   out.res = a_ext + 1;
            CMD_DEC_A:   out.res = a_ext - 1;
            CMD_INC_B:   out.res = b_ext + 1;
            CMD_DEC_B:   out.res = b_ext - 1;
            CMD_CMP: begin
                out.flags.g = req.opa > req.opb;
                out.flags.l = req.opa < req.opb;
                out.flags.e = req.opa == req.opb;
            end
            CMD_SADD: begin
                out.res         = a_sext + b_sext;
                out.flags.oflow = (msb_a == msb_b) && (out.res[`ALU_WIDTH-1] != msb_a);
            end
            CMD_SSUB: begin
                out.res         = a_sext - b_sext;
                out.flags.oflow = (msb_a != msb_b) && (out.res[`ALU_WIDTH-1] != msb_a);
            end
            default: out = '0;
        endcase

        // unsigned add/sub report the ninth bit as both carry and overflow.
        if (cmd == CMD_ADD || cmd == CMD_SUB || cmd == CMD_ADD_CIN || cmd == CMD_SUB_CIN) begin
            out.flags.cout  = out.res[`ALU_WIDTH];
            out.flags.oflow = out.res[`ALU_WIDTH];
        end

        if (cmd == CMD_SADD || cmd == CMD_SSUB) begin
            out.flags.cout = out.res[`ALU_WIDTH];
            out.flags.neg  = out.res[`ALU_WIDTH-1];
            out.flags.zero = out.res[`ALU_WIDTH-1:0] == '0;
            out.flags.g    = a_s > b_s;
            out.flags.l    = a_s < b_s;
            out.flags.e    = a_s == b_s;
        end
    end

endmodule

//--- alu_cmd_pkg.sv
`include "alu_consts.svh"

package alu_cmd_pkg;

    typedef enum logic {
        MODE_LOGIC = 1'b0,
        MODE_ARITH = 1'b1
    } alu_mode_e;

    // codes 11 to 15 are illegal.
    typedef enum logic [`ALU_CMD_BITS-1:0] {
        CMD_ADD,
        CMD_SUB,
        CMD_ADD_CIN,
        CMD_SUB_CIN,
        CMD_INC_A,
        CMD_DEC_A,
        CMD_INC_B,
        CMD_DEC_B,
        CMD_CMP,
        CMD_SADD,
        CMD_SSUB
    } arith_cmd_e;

    // codes 14 and 15 are illegal.
    typedef enum logic [`ALU_CMD_BITS-1:0] {
        CMD_AND,
        CMD_NAND,
        CMD_OR,
        CMD_NOR,
        CMD_XOR,
        CMD_XNOR,
        CMD_NOT_A,
        CMD_NOT_B,
        CMD_SHR1_A,
        CMD_SHL1_A,
        CMD_SHR1_B,
        CMD_SHL1_B,
        CMD_ROL,
        CMD_ROR
    } logic_cmd_e;

    // operands a command reads; zero marks an illegal command.
    function automatic logic [`ALU_NEED_BITS-1:0] operand_need(
        alu_mode_e                 mode,
        logic [`ALU_CMD_BITS-1:0]  cmd
    );
        logic [`ALU_NEED_BITS-1:0] need;
        need = `ALU_NEED_NONE;
        if (mode == MODE_ARITH) begin
            case (arith_cmd_e'(cmd))
                CMD_INC_A, CMD_DEC_A: need = `ALU_NEED_A;
                CMD_INC_B, CMD_DEC_B: need = `ALU_NEED_B;
                CMD_ADD, CMD_SUB, CMD_ADD_CIN, CMD_SUB_CIN,
                CMD_CMP, CMD_SADD, CMD_SSUB: need = `ALU_NEED_AB;
                default: need = `ALU_NEED_NONE;
            endcase
        end else begin
            case (logic_cmd_e'(cmd))
                CMD_NOT_A, CMD_SHR1_A, CMD_SHL1_A: need = `ALU_NEED_A;
                CMD_NOT_B, CMD_SHR1_B, CMD_SHL1_B: need = `ALU_NEED_B;
                CMD_AND, CMD_NAND, CMD_OR, CMD_NOR, CMD_XOR, CMD_XNOR,
                CMD_ROL, CMD_ROR: need = `ALU_NEED_AB;
                default: need = `ALU_NEED_NONE;
            endcase
        end
        return need;
    endfunction

endpackage

//--- alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operand and result widths.
`define ALU_WIDTH       8
`define ALU_RES_BITS    (`ALU_WIDTH + 1)

// command field and rotate amount.
`define ALU_CMD_BITS    4
`define ALU_SHAMT_BITS  3

// operand-need mask with bit 0 for A and bit 1 for B.
`define ALU_NEED_BITS   2
`define ALU_NEED_NONE   2'b00
`define ALU_NEED_A      2'b01
`define ALU_NEED_B      2'b10
`define ALU_NEED_AB     2'b11

`endif

//--- alu_data_pkg.sv
`include "alu_consts.svh"

package alu_data_pkg;

    // one request as it enters the pipeline.
    typedef struct packed {
        alu_cmd_pkg::alu_mode_e          mode;
        logic [`ALU_CMD_BITS-1:0]        cmd;
        logic [`ALU_WIDTH-1:0]           opa;
        logic [`ALU_WIDTH-1:0]           opb;
        logic                            cin;
        logic [`ALU_NEED_BITS-1:0]       inp_valid;
        logic                            req_err;
    } alu_req_t;

    typedef struct packed {
        logic cout;
        logic oflow;
        logic g;
        logic l;
        logic e;
        logic neg;
        logic zero;
        logic err;
    } alu_flags_t;

    typedef struct packed {
        logic [`ALU_RES_BITS-1:0] res;
        alu_flags_t               flags;
    } alu_out_t;

endpackage

//--- alu_logic_unit.sv
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_logic_unit (
    input  alu_data_pkg::alu_req_t req,
    output alu_data_pkg::alu_out_t out
);
    import alu_cmd_pkg::*;

    logic_cmd_e                  cmd;
    logic [`ALU_SHAMT_BITS-1:0]  shamt;
    logic [2*`ALU_WIDTH-1:0]     rol_wide;
    logic [2*`ALU_WIDTH-1:0]     ror_wide;
    logic                        rot_err;

    assign cmd   = logic_cmd_e'(req.cmd);
    assign shamt = req.opb[`ALU_SHAMT_BITS-1:0];

    // a doubled copy of A turns a shift into a rotate.
    assign rol_wide = {req.opa, req.opa} << shamt;
    assign ror_wide = {req.opa, req.opa} >> shamt;

    // amount bits above the rotate range are an error.
    assign rot_err = |req.opb[`ALU_WIDTH-1:`ALU_SHAMT_BITS];

    always_comb begin
        out = '0;
        case (cmd)
            CMD_AND:    out.res = {1'b0, req.opa & req.opb};
            CMD_NAND:   out.res = {1'b0, ~(req.opa & req.opb)};
            CMD_OR:     out.res = {1'b0, req.opa | req.opb};
            CMD_NOR:    out.res = {1'b0, ~(req.opa | req.opb)};
            CMD_XOR:    out.res = {1'b0, req.opa ^ req.opb};
            CMD_XNOR:   out.res = {1'b0, ~(req.opa ^ req.opb)};
            CMD_NOT_A:  out.res = {1'b0, ~req.opa};
            CMD_NOT_B:  out.res = {1'b0, ~req.opb};
            CMD_SHR1_A: out.res = {2'b00, req.opa[`ALU_WIDTH-1:1]};
            CMD_SHL1_A: out.res = {req.opa, 1'b0};
            CMD_SHR1_B: out.res = {2'b00, req.opb[`ALU_WIDTH-1:1]};
            CMD_SHL1_B: out.res = {req.opb, 1'b0};
            CMD_ROL: begin
                out.res       = {1'b0, rol_wide[2*`ALU_WIDTH-1:`ALU_WIDTH]};
                out.flags.err = rot_err;
            end
            CMD_ROR: begin
                out.res       = {1'b0, ror_wide[`ALU_WIDTH-1:0]};
                out.flags.err = rot_err;
            end
            default: out = '0;
        endcase
    end

endmodule

//--- alu_operand_stage.sv
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_operand_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ce,
    input  alu_data_pkg::alu_req_t req,
    output alu_data_pkg::alu_req_t req_q
);
    import alu_cmd_pkg::*;

    logic [`ALU_NEED_BITS-1:0] need;
    logic                      req_err;

    assign need = operand_need(req.mode, req.cmd);

    // illegal command, or a needed operand is not flagged valid.
    assign req_err = (need == `ALU_NEED_NONE) || ((need & req.inp_valid) != need);

    // cleared request decodes as a logic-mode AND of zeros.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= '0;
        end else if (ce) begin
            req_q         <= req;
            req_q.req_err <= req_err;
        end
    end

endmodule

//--- alu_result_stage.sv
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_result_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ce,
    input  alu_data_pkg::alu_req_t req,
    input  alu_data_pkg::alu_out_t arith,
    input  alu_data_pkg::alu_out_t logic_out,
    output alu_data_pkg::alu_out_t out
);
    import alu_cmd_pkg::*;
    import alu_data_pkg::*;

    alu_out_t sel;

    // a rejected request shows only err.
    always_comb begin
        if (req.req_err) begin
            sel           = '0;
            sel.flags.err = 1'b1;
        end else if (req.mode == MODE_ARITH) begin
            sel = arith;
        end else begin
            sel = logic_out;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out <= '0;
        end else if (ce) begin
            out <= sel;
        end
    end

endmodule

//--- alu_top.sv
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ce,
    input  logic                       mode,
    input  logic                       cin,
    input  logic [`ALU_NEED_BITS-1:0]  inp_valid,
    input  logic [`ALU_CMD_BITS-1:0]   cmd,
    input  logic [`ALU_WIDTH-1:0]      opa,
    input  logic [`ALU_WIDTH-1:0]      opb,
    output logic [`ALU_RES_BITS-1:0]   res,
    output logic                       oflow,
    output logic                       cout,
    output logic                       g,
    output logic                       l,
    output logic                       e,
    output logic                       err,
    output logic                       neg,
    output logic                       zero
);
    import alu_cmd_pkg::*;
    import alu_data_pkg::*;

    alu_req_t req_in;
    alu_req_t req_q;
    alu_out_t arith_out;
    alu_out_t logic_out;
    alu_out_t out_q;

    // req_err is filled in by the operand stage.
    assign req_in = '{
        mode:      alu_mode_e'(mode),
        cmd:       cmd,
        opa:       opa,
        opb:       opb,
        cin:       cin,
        inp_valid: inp_valid,
        req_err:   1'b0
    };

    alu_operand_stage i_operand_stage (
        .clk   (clk),
        .rst   (rst),
        .ce    (ce),
        .req   (req_in),
        .req_q (req_q)
    );

    alu_arith_unit i_arith_unit (
        .req (req_q),
        .out (arith_out)
    );

    alu_logic_unit i_logic_unit (
        .req (req_q),
        .out (logic_out)
    );

    alu_result_stage i_result_stage (
        .clk       (clk),
        .rst       (rst),
        .ce        (ce),
        .req       (req_q),
        .arith     (arith_out),
        .logic_out (logic_out),
        .out       (out_q)
    );

    assign res   = out_q.res;
    assign cout  = out_q.flags.cout;
    assign oflow = out_q.flags.oflow;
    assign g     = out_q.flags.g;
    assign l     = out_q.flags.l;
    assign e     = out_q.flags.e;
    assign neg   = out_q.flags.neg;
    assign zero  = out_q.flags.zero;
    assign err   = out_q.flags.err;

endmodule

//--- list.f
+incdir+.
alu_cmd_pkg.sv
alu_data_pkg.sv
alu_operand_stage.sv
alu_arith_unit.sv
alu_logic_unit.sv
alu_result_stage.sv
alu_top.sv
tb_alu_top.sv

//--- tb_alu_vectors.svh
`ifndef TB_ALU_VECTORS_SVH
`define TB_ALU_VECTORS_SVH

// columns are mode, cmd, opa, opb, cin, inp_valid, expected res, expected flags.
// flag bits from left to right are cout, oflow, g, l, e, neg, zero, err.
localparam int NUM_VECTORS = 42;

vec_t vectors [NUM_VECTORS] = '{
    '{MODE_ARITH, CMD_ADD,     8'h12, 8'h34, 1'b0, 2'b11, 9'h046, 8'b0000_0000},
    '{MODE_ARITH, CMD_ADD,     8'hff, 8'h01, 1'b0, 2'b11, 9'h100, 8'b1100_0000},
    '{MODE_ARITH, CMD_SUB,     8'h50, 8'h20, 1'b0, 2'b11, 9'h030, 8'b0000_0000},
    '{MODE_ARITH, CMD_SUB,     8'h00, 8'h01, 1'b0, 2'b11, 9'h1ff, 8'b1100_0000},
    '{MODE_ARITH, CMD_ADD_CIN, 8'h10, 8'h20, 1'b1, 2'b11, 9'h031, 8'b0000_0000},
    '{MODE_ARITH, CMD_ADD_CIN, 8'hff, 8'h00, 1'b1, 2'b11, 9'h100, 8'b1100_0000},
    '{MODE_ARITH, CMD_SUB_CIN, 8'h10, 8'h05, 1'b1, 2'b11, 9'h00a, 8'b0000_0000},
    '{MODE_ARITH, CMD_INC_A,   8'hff, 8'h00, 1'b0, 2'b01, 9'h100, 8'b0000_0000},
    '{MODE_ARITH, CMD_DEC_A,   8'h00, 8'h00, 1'b0, 2'b01, 9'h1ff, 8'b0000_0000},
    '{MODE_ARITH, CMD_INC_B,   8'h00, 8'h41, 1'b0, 2'b10, 9'h042, 8'b0000_0000},
    '{MODE_ARITH, CMD_DEC_B,   8'h00, 8'h41, 1'b0, 2'b10, 9'h040, 8'b0000_0000},
    '{MODE_ARITH, CMD_CMP,     8'h80, 8'h7f, 1'b0, 2'b11, 9'h000, 8'b0010_0000},
    '{MODE_ARITH, CMD_CMP,     8'h10, 8'h20, 1'b0, 2'b11, 9'h000, 8'b0001_0000},
    '{MODE_ARITH, CMD_CMP,     8'h33, 8'h33, 1'b0, 2'b11, 9'h000, 8'b0000_1000},
    // signed overflow both ways, a zero and a negative result.
    '{MODE_ARITH, CMD_SADD,    8'h7f, 8'h01, 1'b0, 2'b11, 9'h080, 8'b0110_0100},
    '{MODE_ARITH, CMD_SADD,    8'h80, 8'hff, 1'b0, 2'b11, 9'h17f, 8'b1101_0000},
    '{MODE_ARITH, CMD_SADD,    8'h05, 8'hfb, 1'b0, 2'b11, 9'h000, 8'b0010_0010},
    '{MODE_ARITH, CMD_SSUB,    8'h03, 8'h05, 1'b0, 2'b11, 9'h1fe, 8'b1001_0100},
    '{MODE_ARITH, CMD_SSUB,    8'h80, 8'h01, 1'b0, 2'b11, 9'h17f, 8'b1101_0000},
    '{MODE_ARITH, CMD_SSUB,    8'h22, 8'h22, 1'b0, 2'b11, 9'h000, 8'b0000_1010},
    '{MODE_LOGIC, CMD_AND,     8'hca, 8'h5c, 1'b0, 2'b11, 9'h048, 8'b0000_0000},
    '{MODE_LOGIC, CMD_NAND,    8'hca, 8'h5c, 1'b0, 2'b11, 9'h0b7, 8'b0000_0000},
    '{MODE_LOGIC, CMD_OR,      8'hca, 8'h5c, 1'b0, 2'b11, 9'h0de, 8'b0000_0000},
    '{MODE_LOGIC, CMD_NOR,     8'hca, 8'h5c, 1'b0, 2'b11, 9'h021, 8'b0000_0000},
    '{MODE_LOGIC, CMD_XOR,     8'hca, 8'h5c, 1'b0, 2'b11, 9'h096, 8'b0000_0000},
    '{MODE_LOGIC, CMD_XNOR,    8'hca, 8'h5c, 1'b0, 2'b11, 9'h069, 8'b0000_0000},
    '{MODE_LOGIC, CMD_NOT_A,   8'hca, 8'h00, 1'b0, 2'b01, 9'h035, 8'b0000_0000},
    '{MODE_LOGIC, CMD_NOT_B,   8'h00, 8'h5c, 1'b0, 2'b10, 9'h0a3, 8'b0000_0000},
    '{MODE_LOGIC, CMD_SHR1_A,  8'hca, 8'h00, 1'b0, 2'b01, 9'h065, 8'b0000_0000},
    '{MODE_LOGIC, CMD_SHL1_A,  8'hca, 8'h00, 1'b0, 2'b01, 9'h194, 8'b0000_0000},
    '{MODE_LOGIC, CMD_SHR1_B,  8'h00, 8'h5c, 1'b0, 2'b10, 9'h02e, 8'b0000_0000},
    '{MODE_LOGIC, CMD_SHL1_B,  8'h00, 8'h81, 1'b0, 2'b10, 9'h102, 8'b0000_0000},
    '{MODE_LOGIC, CMD_ROL,     8'hca, 8'h00, 1'b0, 2'b11, 9'h0ca, 8'b0000_0000},
    '{MODE_LOGIC, CMD_ROL,     8'hca, 8'h03, 1'b0, 2'b11, 9'h056, 8'b0000_0000},
    '{MODE_LOGIC, CMD_ROR,     8'hca, 8'h03, 1'b0, 2'b11, 9'h059, 8'b0000_0000},
    '{MODE_LOGIC, CMD_ROR,     8'hca, 8'h07, 1'b0, 2'b11, 9'h095, 8'b0000_0000},
    '{MODE_LOGIC, CMD_ROL,     8'hca, 8'h08, 1'b0, 2'b11, 9'h0ca, 8'b0000_0001},
    // rejected requests.
    '{MODE_ARITH, CMD_ADD,     8'h12, 8'h34, 1'b0, 2'b10, 9'h000, 8'b0000_0001},
    '{MODE_LOGIC, CMD_NOT_B,   8'h00, 8'h5c, 1'b0, 2'b01, 9'h000, 8'b0000_0001},
    '{MODE_LOGIC, CMD_AND,     8'hca, 8'h5c, 1'b0, 2'b00, 9'h000, 8'b0000_0001},
    '{MODE_ARITH, 4'd11,       8'h12, 8'h34, 1'b0, 2'b11, 9'h000, 8'b0000_0001},
    '{MODE_LOGIC, 4'd14,       8'hca, 8'h5c, 1'b0, 2'b11, 9'h000, 8'b0000_0001}
};

`endif

//--- tb_alu_top.sv
`timescale 1ns/100ps
`include "alu_consts.svh"

module tb_alu_top;
    import alu_cmd_pkg::*;

    // one request with the outputs it should produce.
    typedef struct packed {
        logic                      mode;
        logic [`ALU_CMD_BITS-1:0]  cmd;
        logic [`ALU_WIDTH-1:0]     opa;
        logic [`ALU_WIDTH-1:0]     opb;
        logic                      cin;
        logic [`ALU_NEED_BITS-1:0] inp_valid;
        logic [`ALU_RES_BITS-1:0]  res;
        logic [7:0]                flags;
    } vec_t;

    `include "tb_alu_vectors.svh"

    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 24;
    localparam int STALL_ROW    = 20;
    localparam int CYCLE_LIMIT  = 2 * (NUM_VECTORS + NUM_RANDOM) + RESET_CYCLES + 50;

    logic                      clk;
    logic                      rst;
    logic                      ce;
    logic                      mode;
    logic                      cin;
    logic [`ALU_NEED_BITS-1:0] inp_valid;
    logic [`ALU_CMD_BITS-1:0]  cmd;
    logic [`ALU_WIDTH-1:0]     opa;
    logic [`ALU_WIDTH-1:0]     opb;
    logic [`ALU_RES_BITS-1:0]  res;
    logic [7:0]                obs_flags;

    string flag_names [8] = '{"cout", "oflow", "g", "l", "e", "neg", "zero", "err"};
    int    errors       = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    cycles       = 0;

    alu_top i_alu_top (
        .clk       (clk),
        .rst       (rst),
        .ce        (ce),
        .mode      (mode),
        .cin       (cin),
        .inp_valid (inp_valid),
        .cmd       (cmd),
        .opa       (opa),
        .opb       (opb),
        .res       (res),
        .cout      (obs_flags[7]),
        .oflow     (obs_flags[6]),
        .g         (obs_flags[5]),
        .l         (obs_flags[4]),
        .e         (obs_flags[3]),
        .neg       (obs_flags[2]),
        .zero      (obs_flags[1]),
        .err       (obs_flags[0])
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [8:0] got, input logic [8:0] exp);
        if (got !== exp) begin
            $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs(input logic [8:0] exp_res, input logic [7:0] exp_flags);
        check_value("res", res, exp_res);
        for (int b = 0; b < 8; b++) begin
            check_value(flag_names[b], {8'h00, obs_flags[7-b]}, {8'h00, exp_flags[7-b]});
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors > err_before) begin
            tests_failed++;
            $display("%s failed", name);
        end else begin
            $display("%s ok", name);
        end
    endtask

    task automatic drive_row(input vec_t row);
        mode      = row.mode;
        cmd       = row.cmd;
        opa       = row.opa;
        opb       = row.opb;
        cin       = row.cin;
        inp_valid = row.inp_valid;
    endtask

    // expected signed add worked out in integer arithmetic.
    function automatic vec_t signed_add_row(input logic [7:0] a, input logic [7:0] b);
        vec_t       row;
        int         sa;
        int         sb;
        int         sum;
        logic [8:0] r;
        sa  = {{24{a[7]}}, a};
        sb  = {{24{b[7]}}, b};
        sum = sa + sb;
        r   = sum[8:0];
        row = '0;
        row.mode      = MODE_ARITH;
        row.cmd       = CMD_SADD;
        row.opa       = a;
        row.opb       = b;
        row.inp_valid = 2'b11;
        row.res       = r;
        row.flags     = {r[8], (sum > 127) || (sum < -128), sa > sb, sa < sb, sa == sb,
                         r[7], r[7:0] == 8'h00, 1'b0};
        return row;
    endfunction

    initial begin
        vec_t        rows [$];
        integer      seed;
        logic [31:0] rnd;
        logic [31:0] rnd_b;
        int          err_before;
        rst       = 1'b1;
        ce        = 1'b0;
        mode      = 1'b0;
        cin       = 1'b0;
        inp_valid = '0;
        cmd       = '0;
        opa       = '0;
        opb       = '0;
        seed      = 32'h59bc;

        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst = 1'b0;
        err_before = errors;
        check_outputs('0, '0);
        report_test("reset", err_before);

        foreach (vectors[k]) rows.push_back(vectors[k]);
        for (int k = 0; k < NUM_RANDOM; k++) begin
            rnd   = $random(seed);
            rnd_b = $random(seed);
            rows.push_back(signed_add_row(rnd[7:0], rnd_b[7:0]));
        end

        // each row shows up two enabled cycles after it is driven.
        for (int i = 0; i < rows.size() + 2; i++) begin
            @(posedge clk);
            #2;
            if (i >= 2) begin
                err_before = errors;
                check_outputs(rows[i-2].res, rows[i-2].flags);
                report_test($sformatf("vector %0d", i - 2), err_before);
            end
            if (i < rows.size()) begin
                drive_row(rows[i]);
            end else begin
                drive_row('0);
            end
            ce = 1'b1;
            if (i == STALL_ROW) begin
                ce = 1'b0;
                err_before = errors;
                repeat (3) begin
                    @(posedge clk);
                    #2;
                    check_outputs(rows[i-2].res, rows[i-2].flags);
                end
                ce = 1'b1;
                report_test("ce stall hold", err_before);
            end
        end

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
